// ==== lpbk_pkg.sv ====
// ============================
// Shared widths, limits and vector types for the host memory loopback
// engine. RTL modules and the testbench pull these in with a wildcard
// import of lpbk_pkg.
// ============================

`default_nettype none

package lpbk_pkg;

    // Line address width. Addresses count whole lines, not bytes
    localparam int LINE_ADDR_W = 32;

    // One data line on the R and W channels
    localparam int DATA_W = 64;

    // AXI ID width
    // Bit 0 flags the final burst and bits 3:1 hold a wrapping counter
    localparam int ID_W = 4;

    // Burst size exponent, so bursts are 1, 2, 4 or 8 lines
    localparam int REQ_LEN_LOG2_W = 2;

    // 1-based burst length, big enough to hold 8
    localparam int BURST_LEN_W = 4;

    // AXI 0-based length field
    localparam int AXI_LEN_W = 8;

    // Line count field. It holds the number of lines minus one
    localparam int NUM_LINES_W = 20;

    // Limit on read lines in flight. The active counter is one bit
    // wider than the log2 so its top bit flags the limit
    localparam int RD_MAX_ACTIVE_LINES = 256;
    localparam int RD_ACTIVE_TEST_BIT = $clog2(RD_MAX_ACTIVE_LINES);

    // Depth of the read response ID queue, as a log2
    localparam int ID_FIFO_DEPTH_LOG2 = 2;

    typedef logic [LINE_ADDR_W-1:0]    line_addr_t;
    typedef logic [DATA_W-1:0]         line_data_t;
    typedef logic [ID_W-1:0]           axi_id_t;
    typedef logic [REQ_LEN_LOG2_W-1:0] req_len_log2_t;
    typedef logic [BURST_LEN_W-1:0]    burst_len_t;
    typedef logic [AXI_LEN_W-1:0]      axi_len_t;
    typedef logic [NUM_LINES_W-1:0]    num_lines_t;

endpackage

`default_nettype wire

// ==== lpbk_rd_engine.sv ====
// ============================
// Read burst generator for the loopback engine. A start pulse latches
// the source buffer and burst size, then AR requests walk the buffer
// one burst at a time. The number of lines in flight is capped so the
// response path can never back up past what memory will hold.
// ============================

`timescale 1ns/1ps
`default_nettype none

module lpbk_rd_engine
    import lpbk_pkg::*;
(
    input  logic          clk,
    input  logic          test_rst_n,
    input  logic          start,
    input  num_lines_t    num_lines,
    input  req_len_log2_t req_len_log2,
    input  line_addr_t    src_addr,
    input  logic          arready,
    input  logic          r_last_done,
    output logic          arvalid,
    output line_addr_t    araddr,
    output axi_len_t      arlen,
    output axi_id_t       arid,
    output logic          rd_done
);

    logic       rd_not_done;
    burst_len_t rd_burst_len;
    num_lines_t num_rd_req_rem;
    line_addr_t rd_addr;
    // Counter half of the ID. Bit 0 is reserved for the final flag
    logic [ID_W-2:0] rd_id;

    logic [RD_ACTIVE_TEST_BIT:0] num_rd_active_lines;
    logic [RD_ACTIVE_TEST_BIT:0] rd_burst_lines;
    logic rd_too_many_active;
    logic rd_is_last;
    logic ar_fire;

    // ============================
    // Burst sequencing
    // ============================

    assign ar_fire    = arvalid && arready;
    assign rd_is_last = (num_rd_req_rem == '0);

    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
        begin
            rd_not_done <= 1'b0;
        end
        else if (start)
        begin
            rd_not_done <= 1'b1;
        end
        else if (ar_fire && rd_is_last)
        begin
            // Final burst accepted, arvalid drops next cycle
            rd_not_done <= 1'b0;
        end
    end

    // Burst parameters and the walking address
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rd_burst_len   <= burst_len_t'(1) << req_len_log2;
            num_rd_req_rem <= num_lines >> req_len_log2;
            rd_addr        <= src_addr;
            rd_id          <= '0;
        end
        else if (rd_not_done && ar_fire)
        begin
            rd_addr        <= rd_addr + line_addr_t'(rd_burst_len);
            num_rd_req_rem <= num_rd_req_rem - 1'b1;
            rd_id          <= rd_id + 1'b1;
        end
    end

    // ============================
    // In-flight line limiter
    // ============================

    assign rd_burst_lines = {{(RD_ACTIVE_TEST_BIT + 1 - BURST_LEN_W){1'b0}}, rd_burst_len};
    assign rd_too_many_active = num_rd_active_lines[RD_ACTIVE_TEST_BIT];

    // Grows by a burst on each AR handshake and shrinks by a burst when
    // the last beat of a response burst is taken
    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
        begin
            num_rd_active_lines <= '0;
        end
        else if (ar_fire != r_last_done)
        begin
            if (ar_fire)
                num_rd_active_lines <= num_rd_active_lines + rd_burst_lines;
            else
                num_rd_active_lines <= num_rd_active_lines - rd_burst_lines;
        end
    end

    // AR channel drive
    assign arvalid = rd_not_done && !rd_too_many_active;
    assign araddr  = rd_addr;
    assign arlen   = axi_len_t'(rd_burst_len - 1'b1);
    // Final flag rides in bit 0 so it survives the trip to the B channel
    assign arid    = {rd_id, rd_is_last};
    assign rd_done = !rd_not_done;

    // Bursts divide the limit evenly, so the counter stops exactly on it
    // and no request goes out while it sits there
    a_rd_limit : assert property (@(posedge clk) disable iff (!test_rst_n)
        rd_too_many_active |->
            (!arvalid && (num_rd_active_lines ==
                          (RD_ACTIVE_TEST_BIT + 1)'(RD_MAX_ACTIVE_LINES))));

endmodule

`default_nettype wire

// ==== lpbk_rsp_id_fifo.sv ====
// ============================
// Skid queue for read response IDs. The ID of every response burst is
// captured on its first beat and held until the write side turns it
// into an AW request. Full back-pressures the R channel in the top.
// ============================

`timescale 1ns/1ps
`default_nettype none

module lpbk_rsp_id_fifo
    import lpbk_pkg::*;
(
    input  logic    clk,
    input  logic    test_rst_n,
    input  logic    rsp_fire,
    input  logic    rsp_last,
    input  axi_id_t rsp_id,
    input  logic    deq,
    output logic    full,
    output axi_id_t id_out,
    output logic    id_valid
);

    axi_id_t id_mem [2**ID_FIFO_DEPTH_LOG2];
    logic [ID_FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [ID_FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [ID_FIFO_DEPTH_LOG2:0]   count;
    logic rsp_sop;
    logic push;

    // Next beat starts a burst once the previous one carried last
    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
            rsp_sop <= 1'b1;
        else if (rsp_fire)
            rsp_sop <= rsp_last;
    end

    assign push = rsp_fire && rsp_sop;

    always_ff @(posedge clk)
    begin
        if (push)
            id_mem[wr_ptr] <= rsp_id;
    end

    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leaves the count alone
            case ({push, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head entry shows the cycle after it is written
    assign id_out   = id_mem[rd_ptr];
    assign id_valid = (count != '0);
    assign full     = count[ID_FIFO_DEPTH_LOG2];

    a_no_push_full : assert property (@(posedge clk) disable iff (!test_rst_n)
        push |-> !full);

    a_no_deq_empty : assert property (@(posedge clk) disable iff (!test_rst_n)
        deq |-> id_valid);

endmodule

`default_nettype wire

// ==== lpbk_wr_engine.sv ====
// ============================
// Write address generator for the loopback engine. Each queued read
// response ID becomes one AW request at the next destination offset.
// The final flag in ID bit 0 closes the address stream, and the same
// flag on the B channel marks the whole copy as committed.
// ============================

`timescale 1ns/1ps
`default_nettype none

module lpbk_wr_engine
    import lpbk_pkg::*;
(
    input  logic          clk,
    input  logic          test_rst_n,
    input  logic          start,
    input  req_len_log2_t req_len_log2,
    input  line_addr_t    dst_addr,
    input  axi_id_t       id_in,
    input  logic          id_valid,
    input  logic          awready,
    input  logic          bvalid,
    input  axi_id_t       bid,
    output logic          id_deq,
    output logic          awvalid,
    output line_addr_t    awaddr,
    output axi_len_t      awlen,
    output axi_id_t       awid,
    output logic          wr_done
);

    logic       wr_addr_not_done;
    logic       wr_not_done;
    burst_len_t wr_burst_len;
    line_addr_t wr_addr;
    logic       aw_fire;
    logic       b_final;

    assign aw_fire = awvalid && awready;
    // bready is tied high in the top, so bvalid alone is a handshake
    assign b_final = bvalid && bid[0];

    // ============================
    // Completion flags
    // ============================

    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
        begin
            wr_addr_not_done <= 1'b0;
            wr_not_done      <= 1'b0;
        end
        else if (start)
        begin
            wr_addr_not_done <= 1'b1;
            wr_not_done      <= 1'b1;
        end
        else
        begin
            // Final AW seen, no more address requests this run
            if (wr_addr_not_done && aw_fire && id_in[0])
                wr_addr_not_done <= 1'b0;
            // Responses come back in order so the flagged one is the last
            if (b_final)
                wr_not_done <= 1'b0;
        end
    end

    // Destination walks forward one burst per accepted AW
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            wr_burst_len <= burst_len_t'(1) << req_len_log2;
            wr_addr      <= dst_addr;
        end
        else if (wr_addr_not_done && aw_fire)
        begin
            wr_addr <= wr_addr + line_addr_t'(wr_burst_len);
        end
    end

    // ============================
    // AW channel
    // ============================

    assign awvalid = id_valid;
    assign id_deq  = id_valid && awready;
    assign awaddr  = wr_addr;
    assign awlen   = axi_len_t'(wr_burst_len - 1'b1);
    // Write ID mirrors the read ID, final flag included
    assign awid    = id_in;
    assign wr_done = !wr_not_done;

    // Once the flagged AW is out the ID queue must stay dry until the
    // next start, since the read side issued nothing past it
    a_aw_quiet : assert property (@(posedge clk) disable iff (!test_rst_n)
        !wr_addr_not_done |-> !awvalid);

endmodule

`default_nettype wire

// ==== lpbk_top.sv ====
// ============================
// Host memory loopback top. Reads a source buffer with AXI-style bursts
// and streams the responses straight back out as writes to a destination
// buffer. Pulse start with the copy parameters held, then wait for done.
// ============================

`timescale 1ns/1ps
`default_nettype none

module lpbk_top
    import lpbk_pkg::*;
(
    input  logic          clk,
    input  logic          test_rst_n,
    input  logic          start,
    input  num_lines_t    num_lines,
    input  req_len_log2_t req_len_log2,
    input  line_addr_t    src_addr,
    input  line_addr_t    dst_addr,
    output logic          done,
    // AR channel
    output logic          arvalid,
    input  logic          arready,
    output line_addr_t    araddr,
    output axi_len_t      arlen,
    output axi_id_t       arid,
    // R channel
    input  logic          rvalid,
    output logic          rready,
    input  line_data_t    rdata,
    input  logic          rlast,
    input  axi_id_t       rid,
    // AW channel
    output logic          awvalid,
    input  logic          awready,
    output line_addr_t    awaddr,
    output axi_len_t      awlen,
    output axi_id_t       awid,
    // W channel
    output logic          wvalid,
    input  logic          wready,
    output line_data_t    wdata,
    output logic          wlast,
    // B channel
    input  logic          bvalid,
    output logic          bready,
    input  axi_id_t       bid
);

    logic    enable_done_out;
    logic    rd_done;
    logic    wr_done;
    logic    r_fire;
    logic    id_fifo_full;
    axi_id_t rsp_id;
    logic    rsp_id_valid;
    logic    rsp_id_deq;

    // Held low from reset until the first start, so done stays low too
    always_ff @(posedge clk)
    begin
        if (!test_rst_n)
            enable_done_out <= 1'b0;
        else if (start)
            enable_done_out <= 1'b1;
    end

    assign done = enable_done_out && rd_done && wr_done;

    // ============================
    // Response path
    // ============================

    // R only moves when both the ID queue and W can take it,
    // so a W stall holds R with nothing dropped
    assign rready = !id_fifo_full && wready;
    assign wvalid = rvalid && !id_fifo_full;
    assign wdata  = rdata;
    assign wlast  = rlast;
    assign r_fire = rvalid && rready;
    assign bready = 1'b1;

    lpbk_rd_engine rd_engine_inst (
        .clk          (clk),
        .test_rst_n   (test_rst_n),
        .start        (start),
        .num_lines    (num_lines),
        .req_len_log2 (req_len_log2),
        .src_addr     (src_addr),
        .arready      (arready),
        .r_last_done  (r_fire && rlast),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .arlen        (arlen),
        .arid         (arid),
        .rd_done      (rd_done)
    );

    lpbk_rsp_id_fifo rsp_id_fifo_inst (
        .clk        (clk),
        .test_rst_n (test_rst_n),
        .rsp_fire   (r_fire),
        .rsp_last   (rlast),
        .rsp_id     (rid),
        .deq        (rsp_id_deq),
        .full       (id_fifo_full),
        .id_out     (rsp_id),
        .id_valid   (rsp_id_valid)
    );

    lpbk_wr_engine wr_engine_inst (
        .clk          (clk),
        .test_rst_n   (test_rst_n),
        .start        (start),
        .req_len_log2 (req_len_log2),
        .dst_addr     (dst_addr),
        .id_in        (rsp_id),
        .id_valid     (rsp_id_valid),
        .awready      (awready),
        .bvalid       (bvalid),
        .bid          (bid),
        .id_deq       (rsp_id_deq),
        .awvalid      (awvalid),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awid         (awid),
        .wr_done      (wr_done)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// ==============================
// Clock and reset source for the loopback testbench.
// Makes a 20 ns clock and holds the active-low reset for two edges.
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
    output logic clk,
    output logic test_rst_n
);

    // Half period of 10 ns gives the 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset is released on the second rising edge so the DUT sees it synchronously
    initial
    begin
        test_rst_n = 1'b0;
        repeat (2) @(posedge clk);
        test_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_lpbk.sv ====
// ==============================
// Testbench for the host memory loopback engine.
// A memory model answers AR with in-order R bursts and collects AW, W and
// B traffic, then each copy is checked against the burst, address, ID and
// data rules. One result line per test and a count line close the run.
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_lpbk
    import lpbk_pkg::*;
();

    logic clk;
    logic test_rst_n;

    // DUT inputs from the stimulus side
    logic          start        = 1'b0;
    num_lines_t    num_lines    = '0;
    req_len_log2_t req_len_log2 = '0;
    line_addr_t    src_addr     = '0;
    line_addr_t    dst_addr     = '0;

    // DUT inputs from the memory model
    logic       arready = 1'b0;
    logic       rvalid  = 1'b0;
    line_data_t rdata   = '0;
    logic       rlast   = 1'b0;
    axi_id_t    rid     = '0;
    logic       awready = 1'b0;
    logic       wready  = 1'b0;
    logic       bvalid  = 1'b0;
    axi_id_t    bid     = '0;

    // DUT outputs
    logic       done;
    logic       arvalid;
    line_addr_t araddr;
    axi_len_t   arlen;
    axi_id_t    arid;
    logic       rready;
    logic       awvalid;
    line_addr_t awaddr;
    axi_len_t   awlen;
    axi_id_t    awid;
    logic       wvalid;
    line_data_t wdata;
    logic       wlast;
    logic       bready;

    // Memory model knobs, set before each copy
    int          stall_pct    = 0;
    int          r_delay_min  = 0;
    int          r_delay_span = 0;
    logic [31:0] salt         = '0;
    line_addr_t  cur_src      = '0;

    // Read bursts accepted but not yet fully returned, oldest first
    line_addr_t pend_addr[$];
    axi_len_t   pend_len[$];
    axi_id_t    pend_id[$];
    longint     pend_due[$];
    int         r_beat    = 0;
    longint     mem_cycle = 0;

    // Traffic logged during the current copy
    line_addr_t ar_addr_log[$];
    axi_len_t   ar_len_log[$];
    axi_id_t    ar_id_log[$];
    line_addr_t aw_addr_log[$];
    axi_len_t   aw_len_log[$];
    axi_id_t    aw_id_log[$];
    line_data_t w_data_log[$];
    logic       w_last_log[$];
    int         w_bursts      = 0;
    int         b_sent        = 0;
    int         inflight      = 0;
    int         inflight_peak = 0;
    logic       job_active    = 1'b0;
    logic       final_b_seen  = 1'b0;
    logic       done_early    = 1'b0;
    logic       rready_leak   = 1'b0;

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;

    tb_clk_gen clk_gen_inst (
        .clk        (clk),
        .test_rst_n (test_rst_n)
    );

    lpbk_top lpbk_top_inst (
        .clk          (clk),
        .test_rst_n   (test_rst_n),
        .start        (start),
        .num_lines    (num_lines),
        .req_len_log2 (req_len_log2),
        .src_addr     (src_addr),
        .dst_addr     (dst_addr),
        .done         (done),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arlen        (arlen),
        .arid         (arid),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rid          (rid),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awid         (awid),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wlast        (wlast),
        .bvalid       (bvalid),
        .bready       (bready),
        .bid          (bid)
    );

    // ==============================
    // Reference model
    // ==============================

    // Source memory contents, every address bit lands in both halves
    function automatic line_data_t src_line_data(line_addr_t addr, logic [31:0] s);
        return {addr ^ s, (addr * 32'h9e37_79b1) + s};
    endfunction

    // A copy moves line i of the source to line i of the destination
    function automatic line_data_t expect_dst_line(int i);
        return src_line_data(cur_src + line_addr_t'(i), salt);
    endfunction

    // Twenty cycles per copied line plus a fixed margin for startup and drain
    function automatic int copy_timeout(int total_lines);
        return 20 * total_lines + 2000;
    endfunction

    function automatic logic random_ready();
        return ($urandom % 100) >= stall_pct;
    endfunction

    // ==============================
    // Memory model
    // ==============================

    always @(posedge clk)
    begin
        int delay;
        if (!test_rst_n)
        begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            bvalid  <= 1'b0;
            r_beat  = 0;
        end
        else
        begin
            mem_cycle = mem_cycle + 1;
            // Done may only show once the flagged B response has been taken
            if (job_active && done && !final_b_seen)
                done_early = 1'b1;
            if (rready && !wready)
                rready_leak = 1'b1;

            if (arvalid && arready)
            begin
                delay = r_delay_min;
                if (r_delay_span > 0)
                    delay = delay + int'($urandom % r_delay_span);
                pend_addr.push_back(araddr);
                pend_len.push_back(arlen);
                pend_id.push_back(arid);
                pend_due.push_back(mem_cycle + delay);
                ar_addr_log.push_back(araddr);
                ar_len_log.push_back(arlen);
                ar_id_log.push_back(arid);
                inflight = inflight + int'(arlen) + 1;
            end

            // Beats go out in request order, the head burst drains first
            if (rvalid && rready)
            begin
                inflight = inflight - 1;
                if (r_beat == int'(pend_len[0]))
                begin
                    pend_addr.delete(0);
                    pend_len.delete(0);
                    pend_id.delete(0);
                    pend_due.delete(0);
                    r_beat = 0;
                end
                else
                begin
                    r_beat = r_beat + 1;
                end
            end
            if (inflight > inflight_peak)
                inflight_peak = inflight;

            if (awvalid && awready)
            begin
                aw_addr_log.push_back(awaddr);
                aw_len_log.push_back(awlen);
                aw_id_log.push_back(awid);
            end
            if (wvalid && wready)
            begin
                w_data_log.push_back(wdata);
                w_last_log.push_back(wlast);
                if (wlast)
                    w_bursts = w_bursts + 1;
            end
            if (bvalid && bready)
            begin
                if (bid[0])
                    final_b_seen = 1'b1;
                b_sent = b_sent + 1;
            end

            arready <= random_ready();
            awready <= random_ready();
            wready  <= random_ready();

            // Head burst is presented once its delay has run out and stays until taken
            if (pend_addr.size() > 0 && mem_cycle >= pend_due[0])
            begin
                rvalid <= 1'b1;
                rdata  <= src_line_data(pend_addr[0] + line_addr_t'(r_beat), salt);
                rlast  <= (r_beat == int'(pend_len[0]));
                rid    <= pend_id[0];
            end
            else
            begin
                rvalid <= 1'b0;
            end

            // A write burst is answered once its address and all its beats are in
            if (b_sent < aw_id_log.size() && b_sent < w_bursts)
            begin
                bvalid <= 1'b1;
                bid    <= aw_id_log[b_sent];
            end
            else
            begin
                bvalid <= 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the copies did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ==============================
    // Checks and test sequence
    // ==============================

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        errors = errors + 1;
        $display("error %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
    endtask

    task automatic report_problem(input string test, input string what);
        errors = errors + 1;
        $display("%s: %s", test, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run = tests_run + 1;
        if (errors == errors_before)
        begin
            $display("%s: passed", name);
        end
        else
        begin
            tests_failed = tests_failed + 1;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic run_copy(input string name, input int lines_field, input int len_log2,
                            input line_addr_t src, input line_addr_t dst,
                            input int stall, input int delay_min, input int delay_span,
                            input bit expect_limit);
        int      burst_cnt;
        int      burst_len;
        int      errors_before;
        int      k;
        axi_id_t exp_id;
        burst_cnt     = (lines_field >> len_log2) + 1;
        burst_len     = 1 << len_log2;
        errors_before = errors;

        // Memory model state is cleared away from the clock edge
        @(negedge clk);
        ar_addr_log.delete();
        ar_len_log.delete();
        ar_id_log.delete();
        aw_addr_log.delete();
        aw_len_log.delete();
        aw_id_log.delete();
        w_data_log.delete();
        w_last_log.delete();
        w_bursts      = 0;
        b_sent        = 0;
        inflight      = 0;
        inflight_peak = 0;
        final_b_seen  = 1'b0;
        done_early    = 1'b0;
        rready_leak   = 1'b0;
        stall_pct     = stall;
        r_delay_min   = delay_min;
        r_delay_span  = delay_span;
        salt          = $urandom;
        cur_src       = src;

        @(posedge clk);
        start        <= 1'b1;
        num_lines    <= num_lines_t'(lines_field);
        req_len_log2 <= req_len_log2_t'(len_log2);
        src_addr     <= src;
        dst_addr     <= dst;
        @(posedge clk);
        start <= 1'b0;
        // The start edge has been taken, so done must already be down
        @(negedge clk);
        if (done !== 1'b0)
            report_mismatch(name, "done after start", 0, done);
        job_active = 1'b1;
        do
            @(posedge clk);
        while (done !== 1'b1);
        @(negedge clk);
        job_active = 1'b0;

        // Read requests walk the source, only the last carries the final flag
        if (ar_addr_log.size() != burst_cnt)
            report_mismatch(name, "AR count", burst_cnt, ar_addr_log.size());
        for (k = 0; k < ar_addr_log.size(); k++)
        begin
            exp_id = axi_id_t'(((k % 8) << 1) | ((k == burst_cnt - 1) ? 1 : 0));
            if (ar_addr_log[k] !== src + line_addr_t'(k * burst_len))
                report_mismatch(name, "araddr", src + line_addr_t'(k * burst_len),
                                ar_addr_log[k]);
            if (ar_len_log[k] !== axi_len_t'(burst_len - 1))
                report_mismatch(name, "arlen", burst_len - 1, ar_len_log[k]);
            if (ar_id_log[k] !== exp_id)
                report_mismatch(name, "arid", exp_id, ar_id_log[k]);
        end

        // Writes mirror the reads in order at the destination
        if (aw_addr_log.size() != burst_cnt)
            report_mismatch(name, "AW count", burst_cnt, aw_addr_log.size());
        for (k = 0; k < aw_addr_log.size(); k++)
        begin
            exp_id = axi_id_t'(((k % 8) << 1) | ((k == burst_cnt - 1) ? 1 : 0));
            if (aw_addr_log[k] !== dst + line_addr_t'(k * burst_len))
                report_mismatch(name, "awaddr", dst + line_addr_t'(k * burst_len),
                                aw_addr_log[k]);
            if (aw_len_log[k] !== axi_len_t'(burst_len - 1))
                report_mismatch(name, "awlen", burst_len - 1, aw_len_log[k]);
            if (aw_id_log[k] !== exp_id)
                report_mismatch(name, "awid", exp_id, aw_id_log[k]);
        end

        if (w_data_log.size() != burst_cnt * burst_len)
            report_mismatch(name, "W beat count", burst_cnt * burst_len, w_data_log.size());
        for (k = 0; k < w_data_log.size(); k++)
        begin
            if (w_data_log[k] !== expect_dst_line(k))
                report_mismatch(name, $sformatf("wdata line %0d", k), expect_dst_line(k),
                                w_data_log[k]);
            if (w_last_log[k] !== ((k % burst_len) == burst_len - 1))
                report_mismatch(name, $sformatf("wlast line %0d", k),
                                (k % burst_len) == burst_len - 1, w_last_log[k]);
        end

        if (!final_b_seen)
            report_problem(name, "done rose without a B response carrying the final flag");
        if (done_early)
            report_problem(name, "done rose before the final B response was taken");
        if (rready_leak)
            report_problem(name, "rready was high in a cycle where wready was low");
        if (inflight_peak > RD_MAX_ACTIVE_LINES)
            report_problem(name, $sformatf("%0d read lines were in flight, over the limit of %0d",
                                           inflight_peak, RD_MAX_ACTIVE_LINES));
        if (expect_limit && inflight_peak != RD_MAX_ACTIVE_LINES)
            report_mismatch(name, "peak read lines in flight", RD_MAX_ACTIVE_LINES,
                            inflight_peak);
        finish_test(name, errors_before);
    endtask

    initial
    begin
        int errors_before;
        void'($urandom(94161));
        cycle_limit = copy_timeout(1 + 32 + 64 + 1024);

        while (test_rst_n !== 1'b1)
            @(posedge clk);
        @(posedge clk);

        // Nothing may move before the first start
        errors_before = errors;
        if (done !== 1'b0)
            report_mismatch("after_reset", "done", 0, done);
        if (arvalid !== 1'b0)
            report_mismatch("after_reset", "arvalid", 0, arvalid);
        if (awvalid !== 1'b0)
            report_mismatch("after_reset", "awvalid", 0, awvalid);
        if (wvalid !== 1'b0)
            report_mismatch("after_reset", "wvalid", 0, wvalid);
        // B is always accepted
        if (bready !== 1'b1)
            report_mismatch("after_reset", "bready", 1, bready);
        finish_test("after_reset", errors_before);

        run_copy("single_line", 0, 0, 32'h0000_1000, 32'h0004_0000, 0, 0, 0, 1'b0);
        run_copy("burst_copy", 31, 2, 32'h0000_2000, 32'h0005_0000, 0, 1, 4, 1'b0);
        run_copy("random_stalls", 63, 1, 32'h0001_0000, 32'h0006_0000, 35, 0, 8, 1'b0);
        // Long response delay lets the requests pile up against the limit
        run_copy("inflight_limit", 1023, 3, 32'h0010_0000, 32'h0020_0000, 0, 300, 200, 1'b1);

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
lpbk_pkg.sv
lpbk_rd_engine.sv
lpbk_rsp_id_fifo.sv
lpbk_wr_engine.sv
lpbk_top.sv
tb_clk_gen.sv
tb_lpbk.sv

// ==== Makefile ====
# Verilator build and run for the loopback engine testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lpbk
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
